// ==== dv/gba_loader_model.svh ====
// Reference model: cartridge image store, payload half-words, expected cartridge info
`ifndef GBA_LOADER_MODEL_SVH
`define GBA_LOADER_MODEL_SVH

logic [7:0] img [256]; // Cartridge image, one byte per address

// Firmware beat order is low half then high half
function automatic logic [15:0] bios_half(input gba_load_pkg::bios_word_t w, input int s);
	return (s == 0) ? w.lo : w.hi;
endfunction

// Record goes out as flags, address, compare, replace, low half first
function automatic logic [15:0] cheat_half(input gba_load_pkg::cheat_code_t rec, input int s);
	logic [31:0] field;
	case (s / 2)
		0:       field = rec.flags;
		1:       field = rec.addr;
		2:       field = rec.compare;
		default: field = rec.replace;
	endcase
	return (s % 2 == 0) ? field[15:0] : field[31:16];
endfunction

// Plain substring search over the bytes in address order
function automatic logic marker_in_image(input int n_bytes);
	logic [71:0] win;
	for (int i = 0; i + 9 <= n_bytes; i++) begin
		for (int k = 0; k < 9; k++) begin
			win[71-8*k -: 8] = img[i+k]; // First byte on top
		end
		if (win == gba_load_pkg::FLASH_MARKER) begin
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

// Sram and remap flags of the first table title equal to the header title
function automatic logic [1:0] quirk_flags();
	logic [95:0] title;
	for (int k = 0; k < gba_load_pkg::TITLE_LEN; k++) begin
		title[95-8*k -: 8] = img[gba_load_pkg::TITLE_ADDR + k];
	end
	for (int i = 0; i < gba_load_pkg::QUIRK_COUNT; i++) begin
		if (title == gba_load_pkg::QUIRK_TABLE[i].title) begin
			return {gba_load_pkg::QUIRK_TABLE[i].sram, gba_load_pkg::QUIRK_TABLE[i].remap};
		end
	end
	return 2'b00; // Unknown title
endfunction

function automatic gba_load_pkg::cart_info_t expect_cart(input logic [7:0] idx,
	input int n_beats);
	gba_load_pkg::cart_info_t info;
	logic [1:0]  q;
	logic [26:0] last_byte; // Address of the final beat
	q         = quirk_flags();
	last_byte = 27'(2 * (n_beats - 1));
	info.loaded      = 1'b1;
	info.cart_type   = idx[7:6];
	info.flash_1m    = marker_in_image(2 * n_beats);
	info.sram_quirk  = q[1];
	info.remap_quirk = q[0];
	info.last_addr   = last_byte[26:2]; // Divided by 4
	return info;
endfunction

`endif

// ==== dv/gba_loader_tb.sv ====
// Loader testbench: clock and reset, LFSR stimulus, output monitors, test sequence, report
`timescale 1ns/10ps

module gba_loader_tb;

	localparam int RESET_CYCLES = 8;
	localparam int GAP          = 16;  // Idle cycles around one download, checks included
	localparam int CART_BEATS   = 128;
	localparam int QN           = gba_load_pkg::QUIRK_COUNT + 1; // Table titles plus one unknown
	localparam int DOWNLOADS    = 1 + 1 + 2 + QN + 1;
	localparam int TOTAL_BEATS  = 64 + 127 + 2 * CART_BEATS + QN * CART_BEATS + 3 * 8;
	localparam int CYCLE_LIMIT  = 2 * (TOTAL_BEATS + DOWNLOADS * GAP + RESET_CYCLES + GAP);

	logic                      clk_sys = 1'b0;
	logic                      reset;
	logic                      download;
	logic [7:0]                index;
	gba_load_pkg::ioctl_beat_t beat;
	logic                      beat_wr;
	logic                      bios_wr;
	gba_load_pkg::bios_write_t bios_write;
	logic                      cheat_valid;
	gba_load_pkg::cheat_code_t cheat_code;
	logic                      cheat_clear;
	gba_load_pkg::cart_info_t  cart_info;

	logic [31:0] lfsr_state = 32'h7fb228ad;
	string       cur_test   = "reset";
	int          errors     = 0;
	int          errors_at_start = 0; // Error count when the current test began
	int          tests_run  = 0;
	int          tests_failed = 0;
	int          cycles     = 0;
	int          bios_count;
	int          cheat_count;
	int          clear_count;

	gba_load_pkg::bios_write_t bios_q [$];  // Expected firmware writes, in order
	gba_load_pkg::cheat_code_t cheat_q [$]; // Expected cheat records

	`include "gba_loader_model.svh"

	always #2 clk_sys = ~clk_sys; // 4 ns period

	gba_loader_top #(.ADDR_W(gba_load_pkg::IOCTL_ADDR_W)) dut_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download    (download),
		.index       (index),
		.beat        (beat),
		.beat_wr     (beat_wr),
		.bios_wr     (bios_wr),
		.bios_write  (bios_write),
		.cheat_valid (cheat_valid),
		.cheat_code  (cheat_code),
		.cheat_clear (cheat_clear),
		.cart_info   (cart_info)
	);

	// ====================
	// Random numbers
	// ====================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// ====================
	// Checks and report
	// ====================
	task automatic check_value(input string what, input logic [127:0] exp,
		input logic [127:0] act);
		if (exp !== act) begin
			errors++;
			$display("Mismatch in %s (%s): expected %0h, actual %0h", cur_test, what, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error in %s: %s", cur_test, msg);
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		bios_count  = 0;
		cheat_count = 0;
		clear_count = 0;
	endtask

	task automatic finish_test();
		if (bios_q.size() != 0 || cheat_q.size() != 0) begin
			report_error("expected output pulses never arrived");
		end
		bios_q.delete();
		cheat_q.delete();
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
		end
		$display("%-10s finished with %0d errors", cur_test, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	// Output pulses, sampled mid-cycle
	always @(negedge clk_sys) begin
		if (!reset) begin
			if (bios_wr) begin
				bios_count++;
				if (bios_q.size() == 0) report_error("firmware write with nothing expected");
				else check_value("bios_write", bios_q.pop_front(), bios_write);
			end
			if (cheat_valid) begin
				cheat_count++;
				if (cheat_q.size() == 0) report_error("cheat record with nothing expected");
				else check_value("cheat_code", cheat_q.pop_front(), cheat_code);
			end
			if (cheat_clear) clear_count++;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles, the tests did not finish in time", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// ====================
	// Stimulus
	// ====================
	task automatic next_cycle();
		@(posedge clk_sys);
		#1; // Inputs change 1 ns after the edge
	endtask

	task automatic start_download(input logic [7:0] idx);
		index    = idx;
		download = 1'b1;
		repeat (3) next_cycle(); // Mode flags settle before the first strobe
	endtask

	task automatic write_beat(input logic [26:0] addr, input logic [15:0] data);
		beat.addr = addr;
		beat.data = data;
		beat_wr   = 1'b1;
		next_cycle();
	endtask

	// Beat address stays put, the last cartridge address is taken from it
	task automatic end_download();
		beat_wr = 1'b0;
		repeat (2) next_cycle();
		download = 1'b0;
		repeat (6) next_cycle();
	endtask

	// Random bytes with no 'F', so no marker can appear by chance
	task automatic fill_image();
		logic [7:0] b;
		for (int i = 0; i < 256; i++) begin
			b = 8'(rand_bits(8));
			img[i] = (b == "F") ? (b ^ 8'h01) : b;
		end
	endtask

	task automatic place_title(input logic [95:0] t);
		for (int k = 0; k < gba_load_pkg::TITLE_LEN; k++) begin
			img[gba_load_pkg::TITLE_ADDR + k] = t[95-8*k -: 8];
		end
	endtask

	task automatic place_marker(input int off);
		for (int k = 0; k < 9; k++) begin
			img[off + k] = gba_load_pkg::FLASH_MARKER[71-8*k -: 8];
		end
	endtask

	function automatic logic [7:0] cart_index();
		logic [7:0] idx;
		idx = 8'(rand_bits(8));
		if (idx == gba_load_pkg::BIOS_INDEX || idx == gba_load_pkg::CODE_INDEX) begin
			idx = 8'h5a; // Pull back into the cartridge range
		end
		return idx;
	endfunction

	task automatic load_cart(input logic [7:0] idx, input int n, input string what);
		start_download(idx);
		for (int i = 0; i < n; i++) begin
			write_beat(27'(2 * i), {img[2*i+1], img[2*i]}); // Even byte in the low half
		end
		end_download();
		check_value(what, expect_cart(idx, n), cart_info);
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		logic [26:0]               base;
		logic [26:0]               wa;
		gba_load_pkg::bios_word_t  word;
		gba_load_pkg::cheat_code_t rec;
		logic [7:0]                idx;
		logic [1:0]                q_exp;
		reset    = 1'b1;
		download = 1'b0;
		index    = 8'd0;
		beat     = '0;
		beat_wr  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		begin_test("reset");
		repeat (2) next_cycle();
		check_value("bios_wr", 0, bios_wr);
		check_value("cheat_valid", 0, cheat_valid);
		check_value("cheat_clear", 0, cheat_clear);
		check_value("cart_info", 0, cart_info);
		finish_test();

		begin_test("firmware");
		base = 27'(rand_bits(12)) << 2; // Word aligned start
		start_download(gba_load_pkg::BIOS_INDEX);
		for (int w = 0; w < 32; w++) begin
			word = rand_bits(32);
			wa   = base + 27'(4 * w);
			bios_q.push_back(gba_load_pkg::bios_write_t'{addr: wa[13:2], word: word});
			for (int s = 0; s < 2; s++) begin
				write_beat(wa + 27'(2 * s), bios_half(word, s));
			end
		end
		end_download();
		check_value("pulse count", 32, bios_count);
		finish_test();

		begin_test("cart_plain");
		fill_image();
		load_cart(cart_index(), 96 + int'(rand_bits(5)), "cart_info");
		finish_test();

		begin_test("flash");
		idx = cart_index();
		fill_image();
		place_marker(int'(8'hC0) + int'(rand_bits(5))); // Odd or even offset
		load_cart(idx, CART_BEATS, "with marker");
		check_value("flash_1m set", 1, cart_info.flash_1m);
		fill_image();
		load_cart(idx, CART_BEATS, "no marker");
		check_value("flash_1m cleared", 0, cart_info.flash_1m);
		finish_test();

		begin_test("quirks");
		for (int e = 0; e < QN; e++) begin
			fill_image();
			if (e < gba_load_pkg::QUIRK_COUNT) begin
				place_title(gba_load_pkg::QUIRK_TABLE[e].title);
				q_exp = {gba_load_pkg::QUIRK_TABLE[e].sram, gba_load_pkg::QUIRK_TABLE[e].remap};
			end else begin
				place_title("NOT A TITLE!");
				q_exp = 2'b00;
			end
			load_cart(cart_index(), CART_BEATS, "cart_info");
			check_value("sram and remap", q_exp, {cart_info.sram_quirk, cart_info.remap_quirk});
		end
		finish_test();

		begin_test("cheats");
		start_download(gba_load_pkg::CODE_INDEX);
		for (int r = 0; r < 3; r++) begin
			rec = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
			cheat_q.push_back(rec);
			for (int s = 0; s < 8; s++) begin
				write_beat(27'(16 * r + 2 * s), cheat_half(rec, s));
			end
		end
		end_download();
		check_value("cheat_clear pulses", 1, clear_count);
		check_value("record count", 3, cheat_count);
		finish_test();

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== hw/cart_scanner.sv ====
// Cartridge scanner: flash marker search, header title capture, quirk table lookup
`timescale 1ns/10ps

module cart_scanner #(
	parameter int ADDR_W = gba_load_pkg::IOCTL_ADDR_W
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      enable,     // Cartridge download active
	input  logic                      cart_start,
	input  logic [7:0]                index,
	input  gba_load_pkg::ioctl_beat_t beat,
	input  logic                      beat_wr,
	input  logic [ADDR_W-3:0]         last_addr,
	output gba_load_pkg::cart_info_t  cart_info
);

	localparam int TITLE_W = gba_load_pkg::TITLE_LEN * 8;

	logic              loaded_q;
	logic [1:0]        type_q;
	logic              flash_q;
	logic              sram_q;
	logic              remap_q;

	logic [63:0]       hist;       // Last eight stream bytes, newest at bottom
	logic [63:0]       hist_cur;   // History as seen by this beat
	logic              marker_hit;
	logic [TITLE_W-1:0] title_buf;
	logic [ADDR_W-1:0] title_off;  // Beat address relative to title start
	logic [6:0]        title_lsb;
	logic              in_title;
	logic              title_done; // Beat just past the title
	logic              q_sram;
	logic              q_remap;
	logic              q_hit;

	// ====================
	// Flash marker search
	// ====================
	assign hist_cur = cart_start ? 64'd0 : hist; // No match across downloads

	// Marker may end at the low byte or at the high byte of this beat
	assign marker_hit = ({hist_cur, beat.data[7:0]} == gba_load_pkg::FLASH_MARKER) ||
		({hist_cur[55:0], beat.data[7:0], beat.data[15:8]} == gba_load_pkg::FLASH_MARKER);

	// ====================
	// Title and quirks
	// ====================
	assign title_off  = beat.addr[ADDR_W-1:0] - ADDR_W'(gba_load_pkg::TITLE_ADDR);
	assign in_title   = (title_off < ADDR_W'(gba_load_pkg::TITLE_LEN)); // Wraps below start
	assign title_lsb  = 7'((gba_load_pkg::TITLE_LEN - 2 - int'(title_off[3:0])) * 8);
	assign title_done = (title_off == ADDR_W'(gba_load_pkg::TITLE_LEN));

	always_comb begin
		q_sram  = 1'b0;
		q_remap = 1'b0;
		q_hit   = 1'b0;
		for (int i = 0; i < gba_load_pkg::QUIRK_COUNT; i++) begin
			if (!q_hit && (title_buf == gba_load_pkg::QUIRK_TABLE[i].title)) begin
				q_sram  = gba_load_pkg::QUIRK_TABLE[i].sram;
				q_remap = gba_load_pkg::QUIRK_TABLE[i].remap;
				q_hit   = 1'b1;                    // First entry wins
			end
		end
	end

	// Stream bytes and title text
	always_ff @(posedge clk_sys) begin
		if (enable && beat_wr) begin
			hist <= {hist_cur[47:0], beat.data[7:0], beat.data[15:8]};
			if (in_title) begin
				title_buf[title_lsb +: 16] <= {beat.data[7:0], beat.data[15:8]};
			end
		end else if (cart_start) begin
			hist <= 64'd0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loaded_q <= 1'b0;
			type_q   <= 2'd0;
			flash_q  <= 1'b0;
			sram_q   <= 1'b0;
			remap_q  <= 1'b0;
		end else begin
			if (cart_start) begin
				loaded_q <= 1'b1;
				type_q   <= index[7:6];
				flash_q  <= 1'b0;
				sram_q   <= 1'b0;
				remap_q  <= 1'b0;
			end
			// Beat updates come last so a strobe at cart_start still counts
			if (enable && beat_wr) begin
				if (marker_hit) flash_q <= 1'b1;
				if (title_done) begin
					sram_q  <= q_sram;
					remap_q <= q_remap;
				end
			end
		end
	end

	assign cart_info = '{
		loaded:      loaded_q,
		cart_type:   type_q,
		flash_1m:    flash_q,
		sram_quirk:  sram_q,
		remap_quirk: remap_q,
		last_addr:   last_addr
	};

	// Save-type flags only move on cartridge traffic
	a_flags_stable: assert property (@(posedge clk_sys) disable iff (reset)
		$changed({flash_q, sram_q, remap_q}) |-> $past(enable || cart_start))
		else $error("cart_scanner: save flags changed outside a cartridge download");

endmodule

// ==== hw/download_classify.sv ====
// Download classifier: registered load kind, start pulses, last cartridge word address
`timescale 1ns/10ps

module download_classify #(
	parameter int ADDR_W = gba_load_pkg::IOCTL_ADDR_W
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      download,
	input  logic [7:0]                index,
	input  gba_load_pkg::ioctl_beat_t beat,
	output gba_load_pkg::load_mode_t  mode,
	output logic                      cart_start,  // Cycle after cartridge flag rises
	output logic                      cheat_clear, // Cycle after a cheat download begins
	output logic [ADDR_W-3:0]         last_addr
);

	logic cart_prev;     // Cartridge flag one cycle back
	logic download_prev; // Host level one cycle back
	logic is_bios;
	logic is_code;

	assign is_bios = (index == gba_load_pkg::BIOS_INDEX);
	assign is_code = (index == gba_load_pkg::CODE_INDEX);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mode          <= '0;
			cart_prev     <= 1'b0;
			download_prev <= 1'b0;
			cart_start    <= 1'b0;
			cheat_clear   <= 1'b0;
			last_addr     <= '0;
		end else begin
			// Kind follows the host with one register stage
			mode.bios <= download && is_bios;
			mode.code <= download && is_code;
			mode.cart <= download && !is_bios && !is_code;

			cart_prev     <= mode.cart;
			download_prev <= download;

			cart_start  <= mode.cart && !cart_prev;                   // Rising edge of flag
			cheat_clear <= download && !download_prev && is_code;    // Rising edge of host level

			// Falling edge, host still shows the final beat address
			if (cart_prev && !mode.cart) begin
				last_addr <= beat.addr[ADDR_W-1:2];
			end
		end
	end

	// Kinds are exclusive
	a_mode_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(mode))
		else $error("download_classify: more than one load kind active");

	// A cartridge start always sits inside a cartridge download
	a_start_in_cart: assert property (@(posedge clk_sys) disable iff (reset)
		cart_start |-> mode.cart)
		else $error("download_classify: cartridge start outside a cartridge download");

endmodule

// ==== hw/gba_load_pkg.sv ====
// Loader package: host stream, load mode, payload and cartridge structs, flash marker, quirk table
package gba_load_pkg;

	// ====================
	// Host download stream
	// ====================
	localparam int IOCTL_ADDR_W = 27;          // Byte address width of the stream

	localparam logic [7:0] BIOS_INDEX = 8'd0;  // Firmware image
	localparam logic [7:0] CODE_INDEX = 8'd255; // Cheat list, any other index is a cartridge

	typedef struct packed {
		logic [IOCTL_ADDR_W-1:0] addr; // Byte address, even on every write
		logic [15:0]             data; // Low byte belongs to the even address
	} ioctl_beat_t;

	typedef struct packed {
		logic bios;
		logic cart;
		logic code;
	} load_mode_t;

	// ====================
	// Packed payloads
	// ====================
	typedef struct packed {
		logic [15:0] hi;
		logic [15:0] lo;
	} bios_word_t;

	typedef struct packed {
		logic [11:0] addr;             // Firmware word address
		bios_word_t  word;
	} bios_write_t;

	// One cheat record, big fields first
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic        loaded;           // Set by the first cartridge download
		logic [1:0]  cart_type;        // Index bits 7:6
		logic        flash_1m;
		logic        sram_quirk;
		logic        remap_quirk;
		logic [IOCTL_ADDR_W-3:0] last_addr; // Word address of the last beat
	} cart_info_t;

	// ====================
	// Cartridge header
	// ====================
	localparam logic [71:0] FLASH_MARKER = "FLASH1M_V"; // 'F' in the top byte

	localparam int TITLE_ADDR = 'hA0;
	localparam int TITLE_LEN  = 12;

	typedef struct packed {
		logic [TITLE_LEN*8-1:0] title; // First character on top, zero padded
		logic                   sram;
		logic                   remap;
	} quirk_entry_t;

	localparam int QUIRK_COUNT = 6;

	// Searched in order, first hit wins
	localparam quirk_entry_t QUIRK_TABLE [QUIRK_COUNT] = '{
		'{title: "ROCKY BOXING",             sram: 1'b1, remap: 1'b0},
		'{title: "DBZ LGCYGOKU",             sram: 1'b1, remap: 1'b0},
		'{title: {"IRIDIONII", 24'h000000},  sram: 1'b1, remap: 1'b0},
		'{title: {"CASTLEVANIA", 8'h00},     sram: 1'b1, remap: 1'b1}, // Classic NES series
		'{title: {"SUPER MARIO", 8'h00},     sram: 1'b1, remap: 1'b1},
		'{title: {"ZELDA 1", 40'h0000000000}, sram: 1'b1, remap: 1'b1}
	};

endpackage

// ==== hw/gba_loader_top.sv ====
// Loader top level: download classifier, firmware and cheat packers, cartridge scanner
`timescale 1ns/10ps

module gba_loader_top #(
	parameter int ADDR_W = gba_load_pkg::IOCTL_ADDR_W
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      download,    // High for a whole download
	input  logic [7:0]                index,
	input  gba_load_pkg::ioctl_beat_t beat,
	input  logic                      beat_wr,     // One cycle per beat
	output logic                      bios_wr,
	output gba_load_pkg::bios_write_t bios_write,
	output logic                      cheat_valid,
	output gba_load_pkg::cheat_code_t cheat_code,
	output logic                      cheat_clear,
	output gba_load_pkg::cart_info_t  cart_info
);

	gba_load_pkg::load_mode_t mode;
	logic                     cart_start;
	logic [ADDR_W-3:0]        last_addr;       // Word address at end of cartridge

	gba_load_pkg::bios_word_t bios_word;
	logic [gba_load_pkg::IOCTL_ADDR_W-3:0] bios_index; // Firmware word number

	// ====================
	// Download kind
	// ====================
	download_classify #(.ADDR_W(ADDR_W)) classify_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download    (download),
		.index       (index),
		.beat        (beat),
		.mode        (mode),
		.cart_start  (cart_start),
		.cheat_clear (cheat_clear),
		.last_addr   (last_addr)
	);

	// ====================
	// Payload packers
	// ====================
	half_word_packer #(.payload_t(gba_load_pkg::bios_word_t)) bios_pack_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.enable     (mode.bios),
		.beat       (beat),
		.beat_wr    (beat_wr),
		.payload    (bios_word),
		.done       (bios_wr),
		.word_index (bios_index)
	);

	assign bios_write = '{addr: bios_index[11:0], word: bios_word}; // 16 KB firmware window

	// Record number is not needed downstream
	half_word_packer #(.payload_t(gba_load_pkg::cheat_code_t)) cheat_pack_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.enable     (mode.code),
		.beat       (beat),
		.beat_wr    (beat_wr),
		.payload    (cheat_code),
		.done       (cheat_valid),
		.word_index ()
	);

	// ====================
	// Cartridge header
	// ====================
	cart_scanner #(.ADDR_W(ADDR_W)) scanner_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.enable     (mode.cart),
		.cart_start (cart_start),
		.index      (index),
		.beat       (beat),
		.beat_wr    (beat_wr),
		.last_addr  (last_addr),
		.cart_info  (cart_info)
	);

endmodule

// ==== hw/half_word_packer.sv ====
// Half-word packer: assembles 16-bit download writes into a wider payload
`timescale 1ns/10ps

module half_word_packer #(
	parameter type payload_t = gba_load_pkg::bios_word_t
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      enable,  // Download of this payload kind active
	input  gba_load_pkg::ioctl_beat_t beat,
	input  logic                      beat_wr,
	output payload_t                  payload,
	output logic                      done,    // Last slot written
	output logic [gba_load_pkg::IOCTL_ADDR_W-$clog2($bits(payload_t)/8)-1:0] word_index
);

	localparam int PAY_W   = $bits(payload_t);
	localparam int HALVES  = PAY_W / 16;         // Slots per payload
	localparam int FIELDS  = PAY_W / 32;         // 32-bit fields, first one on top
	localparam int SLOT_W  = $clog2(HALVES);
	localparam int LSB_W   = $clog2(PAY_W);
	localparam int BYTE_SH = $clog2(PAY_W / 8);  // Address bits inside one payload

	logic [PAY_W-1:0]  pay_q;
	logic [SLOT_W-1:0] slot;      // Half-word slot of the current beat
	logic [LSB_W-1:0]  lane_lsb;  // Bottom bit of that slot in the payload
	logic              last_slot;

	assign slot = beat.addr[SLOT_W:1];

	// Field slot/2 counts down from the top, half slot%2 is low first
	assign lane_lsb  = LSB_W'((FIELDS - 1 - int'(slot >> 1)) * 32 + int'(slot[0]) * 16);
	assign last_slot = (slot == SLOT_W'(HALVES - 1));

	assign payload = payload_t'(pay_q);

	// ====================
	// Payload and index
	// ====================
	always_ff @(posedge clk_sys) begin
		if (enable && beat_wr) begin
			pay_q[lane_lsb +: 16] <= beat.data;
			if (last_slot) begin
				word_index <= beat.addr[gba_load_pkg::IOCTL_ADDR_W-1:BYTE_SH];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= enable && beat_wr && last_slot; // Same cycle as final half lands
		end
	end

	// Odd addresses would split a half-word across slots
	a_even_addr: assert property (@(posedge clk_sys) disable iff (reset)
		(enable && beat_wr) |-> !beat.addr[0])
		else $error("half_word_packer: write strobe with odd byte address");

endmodule

// ==== list.f ====
hw/gba_load_pkg.sv
hw/download_classify.sv
hw/half_word_packer.sv
hw/cart_scanner.sv
hw/gba_loader_top.sv
+incdir+dv
dv/gba_loader_tb.sv
